//--- src/spi_macros.svh
// SPI master register map, FIFO sizing and word format constants
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Data path
`define SPI_WORD_W      32
`define SPI_FIFO_DEPTH  8
`define SPI_CNT_W       4     // Holds 0 up to the full depth

// Words per frame, stored minus one
`define SPI_LEN_W       9

// Register offsets, low five address bits
`define SPI_ADR_CTRL    5'h00
`define SPI_ADR_STAT    5'h04
`define SPI_ADR_RDAT    5'h08
`define SPI_ADR_WDAT    5'h0C
`define SPI_ADR_CMD     5'h10

`endif

//--- src/spi_pkg.sv
// SPI master types for the Wishbone port, the registers and the engine config
`default_nettype none

`include "spi_macros.svh"

package spi_pkg;

   typedef logic [`SPI_WORD_W-1:0] word_t;

   typedef struct packed {
      logic [31:0] adr;
      word_t       dat;
      logic        we;
      logic [3:0]  sel;
      logic        stb;
      logic        cyc;
   } wb_req_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_rsp_t;

   typedef struct packed {
      logic [15:0] div;     // SCK half-period minus one, in clocks
      logic [11:0] rsvd;
      logic        cpol;
      logic        cpha;
      logic        soft_rst;
      logic        en;
   } ctrl_reg_t;

   typedef struct packed {
      logic [17:0]           rsvd_hi;
      logic                  tx_en;
      logic                  rx_en;
      logic [1:0]            rsvd_lo;
      logic                  cs_hold;
      logic [`SPI_LEN_W-1:0] len;
   } cmd_reg_t;

   // Same bus word, CTRL or CMD layout
   typedef union packed {
      ctrl_reg_t ctrl;
      cmd_reg_t  cmd;
   } spi_reg_word_u;

   typedef struct packed {
      logic [25:0] zero;
      logic        busy;
      logic        cs_active;
      logic        rx_empty;
      logic        rx_full;
      logic        tx_empty;
      logic        tx_full;
   } stat_reg_t;

   typedef struct packed {
      logic [15:0]           div;
      logic                  cpol;
      logic                  cpha;
      logic                  cs_hold;
      logic                  tx_en;
      logic                  rx_en;
      logic [`SPI_LEN_W-1:0] len;
   } spi_cfg_t;

endpackage

`default_nettype wire

//--- src/spi_fifo.sv
// SPI word FIFO, circular buffer with occupancy count and head word on the output
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_fifo (
   input  wire                 clk_i,
   input  wire                 reset_i,
   input  wire                 push_i,
   input  wire                 pop_i,
   input  wire spi_pkg::word_t wdata_i,
   output spi_pkg::word_t      rdata_o,
   output logic                full_o,
   output logic                empty_o
);

   import spi_pkg::*;

   localparam int PTR_W = $clog2(`SPI_FIFO_DEPTH);
   localparam logic [PTR_W-1:0] LAST = PTR_W'(`SPI_FIFO_DEPTH - 1);

   word_t                 mem [`SPI_FIFO_DEPTH];
   logic [PTR_W-1:0]      wr_ptr;
   logic [PTR_W-1:0]      rd_ptr;
   logic [`SPI_CNT_W-1:0] count;
   logic                  do_push;
   logic                  do_pop;

   assign full_o  = (count == `SPI_CNT_W'(`SPI_FIFO_DEPTH));
   assign empty_o = (count == '0);
   assign do_push = push_i && !full_o;   // Overflow ignored
   assign do_pop  = pop_i && !empty_o;
   assign rdata_o = mem[rd_ptr];

   always_ff @(posedge clk_i) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

//--- src/spi_regs.sv
// SPI master Wishbone register block, holds CTRL and CMD and starts transfers
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_regs (
   input  wire                   clk_i,
   input  wire                   reset_i,
   input  wire spi_pkg::wb_req_t wb_req_i,
   output spi_pkg::wb_rsp_t      wb_rsp_o,
   input  wire                   tx_full_i,
   input  wire                   tx_empty_i,
   input  wire                   rx_full_i,
   input  wire                   rx_empty_i,
   input  wire spi_pkg::word_t   rx_data_i,
   input  wire                   busy_i,
   input  wire                   cs_active_i,
   input  wire                   done_i,
   output logic                  tx_push_o,
   output logic                  rx_pop_o,
   output spi_pkg::word_t        tx_data_o,
   output spi_pkg::spi_cfg_t     cfg_o,
   output logic                  start_o,
   output logic                  soft_rst_o
);

   import spi_pkg::*;

   ctrl_reg_t     ctrl_q;
   ctrl_reg_t     ctrl_wr;
   cmd_reg_t      cmd_q;
   cmd_reg_t      cmd_wr;
   stat_reg_t     stat;
   spi_reg_word_u wr_word;
   word_t         rd_data;
   word_t         rdat_q;
   logic          ack_q;
   logic          access;
   logic          wr_en;
   logic          rd_en;
   logic [4:0]    adr;

   // Blocked during ack so each request acts once
   assign access = wb_req_i.stb && wb_req_i.cyc && !ack_q;
   assign wr_en  = access && wb_req_i.we;
   assign rd_en  = access && !wb_req_i.we;
   assign adr    = wb_req_i.adr[4:0];

   assign tx_push_o = wr_en && (adr == `SPI_ADR_WDAT) && !tx_full_i;
   assign tx_data_o = wb_req_i.dat;
   assign rx_pop_o  = rd_en && (adr == `SPI_ADR_RDAT) && !rx_empty_i;

   assign wr_word = wb_req_i.dat;

   // Reserved bits read back as zero
   always_comb begin
      ctrl_wr         = wr_word.ctrl;
      ctrl_wr.rsvd    = '0;
      cmd_wr          = wr_word.cmd;
      cmd_wr.rsvd_hi  = '0;
      cmd_wr.rsvd_lo  = '0;
   end

   assign stat = '{
      zero:      '0,
      busy:      busy_i,
      cs_active: cs_active_i,
      rx_empty:  rx_empty_i,
      rx_full:   rx_full_i,
      tx_empty:  tx_empty_i,
      tx_full:   tx_full_i
   };

   always_comb begin
      rd_data = '0;
      case (adr)
         `SPI_ADR_CTRL: rd_data = ctrl_q;
         `SPI_ADR_STAT: rd_data = stat;
         `SPI_ADR_RDAT: rd_data = rx_empty_i ? '0 : rx_data_i;   // Head word
         `SPI_ADR_CMD:  rd_data = cmd_q;
         default:       rd_data = '0;   // WDAT is write only
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdat_q <= rd_data;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ctrl_q <= '0;
         cmd_q  <= '0;
      end else begin
         if (ctrl_q.soft_rst) begin
            ctrl_q.soft_rst <= 1'b0;   // Self clearing
            cmd_q.tx_en     <= 1'b0;   // Drop the aborted command
            cmd_q.rx_en     <= 1'b0;
         end
         if (done_i) begin
            ctrl_q.en   <= 1'b0;
            cmd_q.tx_en <= 1'b0;
            cmd_q.rx_en <= 1'b0;
         end
         if (wr_en && (adr == `SPI_ADR_CTRL)) begin
            ctrl_q <= ctrl_wr;
         end
         if (wr_en && (adr == `SPI_ADR_CMD)) begin
            cmd_q <= cmd_wr;
         end
      end
   end

   assign cfg_o = '{
      div:     ctrl_q.div,
      cpol:    ctrl_q.cpol,
      cpha:    ctrl_q.cpha,
      cs_hold: cmd_q.cs_hold,
      tx_en:   cmd_q.tx_en,
      rx_en:   cmd_q.rx_en,
      len:     cmd_q.len
   };

   // Engine turns busy on the same edge, so this is one cycle wide
   assign start_o    = ctrl_q.en && (cmd_q.tx_en || cmd_q.rx_en) && !busy_i;
   assign soft_rst_o = ctrl_q.soft_rst;
   assign wb_rsp_o   = '{ack: ack_q, dat: rdat_q};

endmodule

`default_nettype wire

//--- src/spi_engine.sv
// SPI shift engine with SCK divider, word sequencing and chip-select timing
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module spi_engine (
   input  wire                    clk_i,
   input  wire                    reset_i,
   input  wire                    soft_rst_i,
   input  wire spi_pkg::spi_cfg_t cfg_i,
   input  wire                    start_i,
   input  wire spi_pkg::word_t    tx_data_i,
   input  wire                    tx_empty_i,
   input  wire                    rx_full_i,
   output logic                   tx_pop_o,
   output logic                   rx_push_o,
   output spi_pkg::word_t         rx_data_o,
   output logic                   busy_o,
   output logic                   cs_active_o,
   output logic                   done_o,
   input  wire                    spi_miso_i,
   output logic                   spi_mosi_o,
   output logic                   spi_sck_o,
   output logic                   spi_cs_o
);

   import spi_pkg::*;

   localparam logic [2:0] S_IDLE  = 3'd0;
   localparam logic [2:0] S_LEAD  = 3'd1;
   localparam logic [2:0] S_SHIFT = 3'd2;
   localparam logic [2:0] S_WAIT  = 3'd3;
   localparam logic [2:0] S_TRAIL = 3'd4;
   localparam int EDGES  = 2 * `SPI_WORD_W;   // Two SCK edges per bit
   localparam int EDGE_W = $clog2(EDGES);
   localparam int MSB    = `SPI_WORD_W - 1;

   logic [2:0]            state;
   spi_cfg_t              cfg_q;
   logic [15:0]           div_cnt;
   logic [EDGE_W-1:0]     edge_cnt;
   logic [`SPI_LEN_W-1:0] word_cnt;   // Words left after the current one
   logic                  first_q;
   word_t                 tx_sr;
   word_t                 rx_sr;
   word_t                 tx_word;
   logic                  sck_q;
   logic                  cs_n_q;
   logic                  mosi_q;
   logic                  tick;
   logic                  edge_now;
   logic                  sample_now;
   logic                  last_edge;
   logic                  bnd;
   logic                  bnd_ok;
   logic                  need_push;
   logic                  need_load;
   logic                  first_c;
   logic                  tx_en_c;
   logic                  cpha_c;

   always_comb begin
      tick       = (div_cnt == '0);
      edge_now   = tick && ((state == S_LEAD) || (state == S_SHIFT));
      // Even edges are leading; cpha 0 samples there
      sample_now = edge_now && (edge_cnt[0] == cfg_q.cpha);
      last_edge  = edge_now && (state == S_SHIFT) && (edge_cnt == EDGE_W'(EDGES - 1));
      // In idle the config is not latched yet
      first_c    = (state == S_IDLE) || first_q;
      tx_en_c    = (state == S_IDLE) ? cfg_i.tx_en : cfg_q.tx_en;
      cpha_c     = (state == S_IDLE) ? cfg_i.cpha : cfg_q.cpha;
      // Word boundary, finish one word and/or begin the next
      bnd        = ((state == S_IDLE) && start_i) || last_edge || (state == S_WAIT);
      need_push  = !first_c && cfg_q.rx_en;
      need_load  = first_c || (word_cnt != '0);
      bnd_ok     = !(need_push && rx_full_i) && !(need_load && tx_en_c && tx_empty_i);
      tx_word    = tx_en_c ? tx_data_i : '0;
   end

   assign tx_pop_o  = bnd && bnd_ok && need_load && tx_en_c;
   assign rx_push_o = bnd && bnd_ok && need_push;
   // Includes the bit sampled on the final edge
   assign rx_data_o = sample_now ? {rx_sr[MSB-1:0], spi_miso_i} : rx_sr;

   assign busy_o      = (state != S_IDLE);
   assign cs_active_o = !cs_n_q;
   assign done_o      = (state == S_TRAIL) && tick;
   assign spi_cs_o    = cs_n_q;
   assign spi_sck_o   = sck_q;
   assign spi_mosi_o  = mosi_q;

   always_ff @(posedge clk_i) begin
      if ((state == S_IDLE) && start_i) begin
         cfg_q <= cfg_i;
      end
      if (sample_now) begin
         rx_sr <= rx_data_o;
      end
      if (bnd && bnd_ok && need_load) begin
         tx_sr <= cpha_c ? tx_word : {tx_word[MSB-1:0], 1'b0};
      end else if (edge_now && !sample_now) begin
         tx_sr <= {tx_sr[MSB-1:0], 1'b0};
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || soft_rst_i) begin
         state    <= S_IDLE;
         div_cnt  <= '0;
         edge_cnt <= '0;
         word_cnt <= '0;
         first_q  <= 1'b0;
         sck_q    <= 1'b0;
         cs_n_q   <= 1'b1;
         mosi_q   <= 1'b0;
      end else begin
         if ((state != S_IDLE) && (state != S_WAIT)) begin
            div_cnt <= tick ? cfg_q.div : div_cnt - 1'b1;
         end
         if (edge_now) begin
            sck_q    <= !sck_q;
            edge_cnt <= edge_cnt + 1'b1;   // Wraps after the last edge
            if (!sample_now) begin
               mosi_q <= tx_sr[MSB];
            end
         end
         case (state)
            S_IDLE: begin
               sck_q <= cfg_i.cpol;
               if (start_i) begin
                  cs_n_q   <= 1'b0;
                  word_cnt <= cfg_i.len;
                  first_q  <= 1'b1;
               end
            end
            S_LEAD:  if (tick) state <= S_SHIFT;
            S_SHIFT: if (last_edge && !bnd_ok) state <= S_WAIT;   // Stall, SCK idle
            S_TRAIL: begin
               if (tick) begin
                  cs_n_q <= !cfg_q.cs_hold;
                  state  <= S_IDLE;
               end
            end
            default: ;
         endcase
         if (bnd && bnd_ok) begin
            first_q  <= 1'b0;
            edge_cnt <= '0;
            div_cnt  <= (state == S_IDLE) ? cfg_i.div : cfg_q.div;
            if (need_load) begin
               if (!first_c) begin
                  word_cnt <= word_cnt - 1'b1;
               end
               if (!cpha_c) begin
                  mosi_q <= tx_word[MSB];   // Set up before the first edge
               end
               state <= S_LEAD;
            end else begin
               state <= S_TRAIL;
            end
         end else if (bnd && (state == S_IDLE)) begin
            state <= S_WAIT;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/spi_top.sv
// SPI master top level joining the register block, both FIFOs and the engine
`timescale 1ns/1ps
`default_nettype none

module spi_top (
   input  wire                   clk_i,
   input  wire                   reset_i,
   input  wire spi_pkg::wb_req_t wb_req_i,
   output spi_pkg::wb_rsp_t      wb_rsp_o,
   input  wire                   spi_miso_i,
   output logic                  spi_mosi_o,
   output logic                  spi_sck_o,
   output logic                  spi_cs_o
);

   import spi_pkg::*;

   spi_cfg_t cfg;
   word_t    tx_wdata;
   word_t    tx_rdata;
   word_t    rx_wdata;
   word_t    rx_rdata;
   logic     tx_push;
   logic     tx_pop;
   logic     tx_full;
   logic     tx_empty;
   logic     rx_push;
   logic     rx_pop;
   logic     rx_full;
   logic     rx_empty;
   logic     start;
   logic     done;
   logic     busy;
   logic     cs_active;
   logic     soft_rst;
   logic     fifo_rst;

   assign fifo_rst = reset_i || soft_rst;   // Soft reset flushes both FIFOs

   spi_regs u_regs (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .wb_req_i    (wb_req_i),
      .wb_rsp_o    (wb_rsp_o),
      .tx_full_i   (tx_full),
      .tx_empty_i  (tx_empty),
      .rx_full_i   (rx_full),
      .rx_empty_i  (rx_empty),
      .rx_data_i   (rx_rdata),
      .busy_i      (busy),
      .cs_active_i (cs_active),
      .done_i      (done),
      .tx_push_o   (tx_push),
      .rx_pop_o    (rx_pop),
      .tx_data_o   (tx_wdata),
      .cfg_o       (cfg),
      .start_o     (start),
      .soft_rst_o  (soft_rst)
   );

   spi_fifo u_tx_fifo (
      .clk_i   (clk_i),
      .reset_i (fifo_rst),
      .push_i  (tx_push),
      .pop_i   (tx_pop),
      .wdata_i (tx_wdata),
      .rdata_o (tx_rdata),
      .full_o  (tx_full),
      .empty_o (tx_empty)
   );

   spi_fifo u_rx_fifo (
      .clk_i   (clk_i),
      .reset_i (fifo_rst),
      .push_i  (rx_push),
      .pop_i   (rx_pop),
      .wdata_i (rx_wdata),
      .rdata_o (rx_rdata),
      .full_o  (rx_full),
      .empty_o (rx_empty)
   );

   spi_engine u_engine (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .soft_rst_i  (soft_rst),
      .cfg_i       (cfg),
      .start_i     (start),
      .tx_data_i   (tx_rdata),
      .tx_empty_i  (tx_empty),
      .rx_full_i   (rx_full),
      .tx_pop_o    (tx_pop),
      .rx_push_o   (rx_push),
      .rx_data_o   (rx_wdata),
      .busy_o      (busy),
      .cs_active_o (cs_active),
      .done_o      (done),
      .spi_miso_i  (spi_miso_i),
      .spi_mosi_o  (spi_mosi_o),
      .spi_sck_o   (spi_sck_o),
      .spi_cs_o    (spi_cs_o)
   );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset source, 10 ns clock with a 16 cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_o,
   output logic reset_o
);

   initial begin
      clk_o = 1'b0;
      forever begin
         #5 clk_o = ~clk_o;
      end
   end

   initial begin
      reset_o = 1'b1;
      repeat (16) @(posedge clk_o);
      @(negedge clk_o);   // Release away from the sampling edge
      reset_o = 1'b0;
   end

endmodule

`default_nettype wire

//--- testbench/tb_spi_top.sv
// Testbench for the SPI master with a Wishbone driver, an SPI slave model and checks
`timescale 1ns/1ps
`default_nettype none

`include "spi_macros.svh"

module tb_spi_top;

   import spi_pkg::*;

   logic        clk_i;
   logic        reset_i;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic        spi_miso_i;
   logic        spi_mosi_o;
   logic        spi_sck_o;
   logic        spi_cs_o;

   logic [15:0] lfsr_state = 16'd40273;
   int unsigned timeout_limit = 2000;
   int unsigned cycle_cnt = 0;
   int          mismatches = 0;
   int          proto_errs = 0;
   int          cur_div;

   // Slave model state
   logic        slv_cpol = 1'b0;
   logic        slv_cpha = 1'b0;
   logic        prev_cs = 1'b1;
   logic        prev_sck = 1'b0;
   word_t       mosi_word;
   word_t       miso_word;
   int          mosi_bits = 0;
   int          miso_bits = 32;
   word_t       mosi_cap[$];
   word_t       miso_pool[$];
   word_t       exp_tx[$];
   word_t       exp_rx[$];

   tb_clock_gen clock_gen (
      .clk_o   (clk_i),
      .reset_o (reset_i)
   );

   spi_top dut (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .wb_req_i   (wb_req),
      .wb_rsp_o   (wb_rsp),
      .spi_miso_i (spi_miso_i),
      .spi_mosi_o (spi_mosi_o),
      .spi_sck_o  (spi_sck_o),
      .spi_cs_o   (spi_cs_o)
   );

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val = {val[30:0], lfsr_state[0]};
         lfsr_state = {1'b0, lfsr_state[15:1]} ^ (lfsr_state[0] ? 16'hB400 : 16'h0000);
      end
      return val;
   endfunction

   function automatic stat_reg_t expect_stat(input logic busy, input logic cs_act,
                                             input logic rxe, input logic rxf,
                                             input logic txe, input logic txf);
      stat_reg_t s;
      s           = '0;
      s.busy      = busy;
      s.cs_active = cs_act;
      s.rx_empty  = rxe;
      s.rx_full   = rxf;
      s.tx_empty  = txe;
      s.tx_full   = txf;
      return s;
   endfunction

   function automatic spi_reg_word_u ctrl_word(input int div, input logic cpol,
                                               input logic cpha, input logic soft_rst,
                                               input logic en);
      spi_reg_word_u w;
      w               = '0;
      w.ctrl.div      = 16'(div);
      w.ctrl.cpol     = cpol;
      w.ctrl.cpha     = cpha;
      w.ctrl.soft_rst = soft_rst;
      w.ctrl.en       = en;
      return w;
   endfunction

   function automatic spi_reg_word_u cmd_word(input logic tx_en, input logic rx_en,
                                              input logic cs_hold, input int len_m1);
      spi_reg_word_u w;
      w             = '0;
      w.cmd.tx_en   = tx_en;
      w.cmd.rx_en   = rx_en;
      w.cmd.cs_hold = cs_hold;
      w.cmd.len     = `SPI_LEN_W'(len_m1);
      return w;
   endfunction

   task automatic report_protocol(input string msg);
      $display("Error: %s", msg);
      proto_errs++;
   endtask

   task automatic check_word(input string name, input word_t got, input word_t exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_stat(input stat_reg_t got, input stat_reg_t exp);
      if (got !== exp) begin
         $display("Mismatch STAT: got %h, expected %h", got, exp);
         mismatches++;
      end
   endtask

   task automatic check_cfg(input string name, input spi_reg_word_u got,
                            input spi_reg_word_u exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         mismatches++;
      end
   endtask

   task automatic check_pin(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
         mismatches++;
      end
   endtask

   // One Wishbone access, entered and left on a falling edge
   task automatic bus_cycle(input logic we, input logic [4:0] adr, input word_t wdat,
                            output word_t rdat);
      int waited;
      wb_req     = '0;
      wb_req.adr = {27'd0, adr};
      wb_req.dat = wdat;
      wb_req.we  = we;
      wb_req.sel = 4'hF;
      wb_req.stb = 1'b1;
      wb_req.cyc = 1'b1;
      rdat       = '0;
      waited     = 0;
      do begin
         @(negedge clk_i);
         waited++;
      end while (!wb_rsp.ack && waited < 16);
      if (wb_rsp.ack) begin
         rdat = wb_rsp.dat;
      end else begin
         report_protocol($sformatf("no ack for the access at offset %h", adr));
      end
      wb_req = '0;
   endtask

   task automatic wb_write(input logic [4:0] adr, input word_t dat);
      word_t unused;
      bus_cycle(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [4:0] adr, output word_t dat);
      bus_cycle(1'b0, adr, '0, dat);
   endtask

   task automatic push_tx(input word_t data);
      wb_write(`SPI_ADR_WDAT, data);
      exp_tx.push_back(data);
   endtask

   // Picks the SCK settings and the slave's words for the next frame
   task automatic prepare_frame(input int nwords, input int div_bits);
      cur_div  = int'(rand_bits(div_bits));
      slv_cpol = 1'(rand_bits(1));
      slv_cpha = 1'(rand_bits(1));
      mosi_cap.delete();
      miso_pool.delete();
      exp_tx.delete();
      exp_rx.delete();
      for (int i = 0; i < nwords; i++) begin
         miso_pool.push_back(rand_bits(32));
         exp_rx.push_back(miso_pool[i]);
      end
      timeout_limit += nwords * 64 * (cur_div + 1);
   endtask

   task automatic launch(input logic tx_en, input logic rx_en, input logic cs_hold,
                         input int nwords);
      spi_reg_word_u w;
      word_t         rd;
      w = ctrl_word(cur_div, slv_cpol, slv_cpha, 1'b0, 1'b0);
      wb_write(`SPI_ADR_CTRL, w);
      wb_read(`SPI_ADR_CTRL, rd);
      check_cfg("CTRL", rd, w);
      w = cmd_word(tx_en, rx_en, cs_hold, nwords - 1);
      wb_write(`SPI_ADR_CMD, w);
      wb_read(`SPI_ADR_CMD, rd);
      check_cfg("CMD", rd, w);
      wb_write(`SPI_ADR_CTRL, ctrl_word(cur_div, slv_cpol, slv_cpha, 1'b0, 1'b1));
   endtask

   task automatic finish_frame(input logic cs_hold);
      word_t     rd;
      stat_reg_t st;
      st = expect_stat(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
      while (st.busy) begin
         wb_read(`SPI_ADR_STAT, rd);
         st = rd;
      end
      if (cs_hold) begin
         check_pin("spi_cs_o", spi_cs_o, 1'b0);
      end else if (spi_cs_o !== 1'b1) begin
         report_protocol("CS did not return high after the frame");
      end
   endtask

   // Slave words against the transmit model, zero where nothing was sent
   task automatic compare_mosi(input int nwords);
      word_t exp;
      if (mosi_cap.size() != nwords) begin
         report_protocol($sformatf("slave captured %0d words, %0d expected",
                                   mosi_cap.size(), nwords));
      end
      for (int i = 0; i < nwords && i < mosi_cap.size(); i++) begin
         exp = (i < exp_tx.size()) ? exp_tx[i] : '0;
         check_word("MOSI word", mosi_cap[i], exp);
      end
   endtask

   task automatic drain_rx(input int nwords);
      word_t rd;
      for (int i = 0; i < nwords; i++) begin
         wb_read(`SPI_ADR_RDAT, rd);
         check_word("RDAT", rd, exp_rx[i]);
      end
   endtask

   task automatic pulse_soft_reset();
      wb_write(`SPI_ADR_CTRL, ctrl_word(cur_div, slv_cpol, slv_cpha, 1'b1, 1'b0));
   endtask

   task automatic capture_mosi_bit();
      mosi_word = {mosi_word[30:0], spi_mosi_o};
      mosi_bits++;
      if (mosi_bits == 32) begin
         mosi_cap.push_back(mosi_word);
         mosi_bits = 0;
      end
   endtask

   task automatic drive_miso_bit();
      if (miso_bits == 32) begin
         if (miso_pool.size() > 0) begin
            miso_word = miso_pool.pop_front();
         end else begin
            miso_word = '0;
         end
         miso_bits = 0;
      end
      spi_miso_i = miso_word[31 - miso_bits];   // MSB first
      miso_bits++;
   endtask

   // SPI slave, reacts on the falling clock edge after SCK or CS moved
   always @(negedge clk_i) begin : spi_slave
      logic leading;
      leading = (spi_sck_o !== slv_cpol);
      if (spi_cs_o === 1'b0 && prev_cs === 1'b1) begin
         mosi_bits = 0;
         miso_bits = 32;
         if (!slv_cpha) begin
            drive_miso_bit();   // First bit ahead of the first edge
         end
      end else if (spi_cs_o === 1'b0 && spi_sck_o !== prev_sck) begin
         if (leading != slv_cpha) begin
            capture_mosi_bit();
         end else begin
            drive_miso_bit();
         end
      end
      prev_cs  = spi_cs_o;
      prev_sck = spi_sck_o;
   end

   // Watchdog, the limit grows with every planned frame
   initial begin
      while (cycle_cnt < timeout_limit) begin
         @(posedge clk_i);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles: %0d mismatches, %0d protocol errors",
               cycle_cnt, mismatches, proto_errs);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      int            n;
      int            nwritten;
      int            nread;
      logic          seen_full;
      word_t         rd;
      stat_reg_t     st;
      wb_req     = '0;
      spi_miso_i = 1'b0;
      @(negedge clk_i);
      while (reset_i !== 1'b0) begin
         @(negedge clk_i);
      end
      @(negedge clk_i);

      // Reset state
      check_pin("spi_cs_o", spi_cs_o, 1'b1);
      check_pin("spi_sck_o", spi_sck_o, 1'b0);
      check_pin("spi_mosi_o", spi_mosi_o, 1'b0);
      wb_read(`SPI_ADR_STAT, rd);
      check_stat(rd, expect_stat(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
      wb_read(`SPI_ADR_CTRL, rd);
      check_cfg("CTRL", rd, '0);
      wb_read(`SPI_ADR_CMD, rd);
      check_cfg("CMD", rd, '0);

      // Transmit only
      repeat (3) begin
         n = int'(rand_bits(3)) + 1;
         prepare_frame(n, 3);
         for (int i = 0; i < n; i++) begin
            push_tx(rand_bits(32));
         end
         launch(1'b1, 1'b0, 1'b0, n);
         finish_frame(1'b0);
         compare_mosi(n);
         wb_read(`SPI_ADR_STAT, rd);
         check_stat(rd, expect_stat(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
      end

      // Receive only, MOSI stays zero
      repeat (2) begin
         n = int'(rand_bits(3)) + 1;
         prepare_frame(n, 3);
         launch(1'b0, 1'b1, 1'b0, n);
         finish_frame(1'b0);
         compare_mosi(n);
         wb_read(`SPI_ADR_STAT, rd);
         check_stat(rd, expect_stat(1'b0, 1'b0, 1'b0, n == `SPI_FIFO_DEPTH, 1'b1, 1'b0));
         drain_rx(n);
         wb_read(`SPI_ADR_RDAT, rd);
         check_word("RDAT", rd, '0);
      end

      // Full duplex, longer than both FIFOs
      repeat (2) begin
         n = 12 + int'(rand_bits(3));
         prepare_frame(n, 2);
         for (int i = 0; i < `SPI_FIFO_DEPTH; i++) begin
            push_tx(rand_bits(32));
         end
         nwritten  = `SPI_FIFO_DEPTH;
         nread     = 0;
         seen_full = 1'b0;
         launch(1'b1, 1'b1, 1'b0, n);
         while (mosi_cap.size() < `SPI_FIFO_DEPTH) begin
            @(negedge clk_i);
         end
         wb_read(`SPI_ADR_STAT, rd);   // Held on the empty transmit FIFO
         check_stat(rd, expect_stat(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0));
         while (nread < n) begin
            wb_read(`SPI_ADR_STAT, rd);
            st = rd;
            // Engine holds once a ninth word ends with eight still unread
            if (!seen_full && mosi_cap.size() > `SPI_FIFO_DEPTH) begin
               repeat (cur_div + 2) begin
                  @(negedge clk_i);   // Past the last SCK edge of that word
               end
               wb_read(`SPI_ADR_STAT, rd);
               st = rd;
               if (!st.busy || !st.rx_full) begin
                  report_protocol("engine did not hold on the full receive FIFO");
               end
               seen_full = 1'b1;
            end
            if (!st.tx_full && nwritten < n) begin
               push_tx(rand_bits(32));
               nwritten++;
            end
            if (!st.rx_empty && seen_full) begin
               wb_read(`SPI_ADR_RDAT, rd);
               check_word("RDAT", rd, exp_rx[nread]);
               nread++;
            end
         end
         finish_frame(1'b0);
         compare_mosi(n);
         wb_read(`SPI_ADR_STAT, rd);
         check_stat(rd, expect_stat(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
      end

      // Nine writes into an idle engine, the last one dropped
      prepare_frame(`SPI_FIFO_DEPTH, 3);
      for (int i = 0; i <= `SPI_FIFO_DEPTH; i++) begin
         rd = rand_bits(32);
         wb_write(`SPI_ADR_WDAT, rd);
         if (i < `SPI_FIFO_DEPTH) begin
            exp_tx.push_back(rd);
         end
      end
      wb_read(`SPI_ADR_STAT, rd);
      check_stat(rd, expect_stat(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1));
      launch(1'b1, 1'b0, 1'b0, `SPI_FIFO_DEPTH);
      finish_frame(1'b0);
      compare_mosi(`SPI_FIFO_DEPTH);
      wb_read(`SPI_ADR_STAT, rd);
      check_stat(rd, expect_stat(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));

      // CS held after the frame, then released by soft reset
      prepare_frame(2, 3);
      push_tx(rand_bits(32));
      push_tx(rand_bits(32));
      launch(1'b1, 1'b0, 1'b1, 2);
      finish_frame(1'b1);
      compare_mosi(2);
      wb_read(`SPI_ADR_STAT, rd);
      check_stat(rd, expect_stat(1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0));
      pulse_soft_reset();
      wb_read(`SPI_ADR_STAT, rd);
      check_stat(rd, expect_stat(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
      check_pin("spi_cs_o", spi_cs_o, 1'b1);

      // Soft reset in the middle of a frame
      prepare_frame(6, 3);
      for (int i = 0; i < 4; i++) begin
         push_tx(rand_bits(32));
      end
      launch(1'b1, 1'b1, 1'b0, 6);
      st = expect_stat(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
      while (st.rx_empty) begin
         wb_read(`SPI_ADR_STAT, rd);
         st = rd;
      end
      pulse_soft_reset();
      wb_read(`SPI_ADR_STAT, rd);
      check_stat(rd, expect_stat(1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0));
      check_pin("spi_cs_o", spi_cs_o, 1'b1);
      wb_read(`SPI_ADR_CTRL, rd);
      check_cfg("CTRL", rd, ctrl_word(cur_div, slv_cpol, slv_cpha, 1'b0, 1'b0));
      wb_read(`SPI_ADR_CMD, rd);
      check_cfg("CMD", rd, cmd_word(1'b0, 1'b0, 1'b0, 5));

      $display("Run complete: %0d mismatches, %0d protocol errors", mismatches, proto_errs);
      if (mismatches == 0 && proto_errs == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+src
src/spi_pkg.sv
src/spi_fifo.sv
src/spi_regs.sv
src/spi_engine.sv
src/spi_top.sv
testbench/tb_clock_gen.sv
testbench/tb_spi_top.sv

//--- Bender.yml
package:
  name: spi_master

sources:
  - include_dirs:
      - src
    files:
      - src/spi_pkg.sv
      - src/spi_fifo.sv
      - src/spi_regs.sv
      - src/spi_engine.sv
      - src/spi_top.sv

  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_spi_top.sv
